//--- clmul_unit.f
rtl/clmul_pkg.sv
rtl/flow_pkg.sv
rtl/poly16_mul.sv
rtl/clmul_ingress.sv
rtl/clmul_core.sv
rtl/clmul_egress.sv
rtl/clmul_unit.sv
tb/clmul_unit_tb.sv

//--- rtl/clmul_core.sv
// Two-stage carry-less multiply pipeline.
// Stage 1 forms three 16-bit Karatsuba products, stage 2 combines them into
// the 64-bit product and registers the word picked by the opcode.

module clmul_core (
  input  logic                 clk_i,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  clmul_pkg::clmul_op_e issue_op,
  input  clmul_pkg::word_t     issue_a,
  input  clmul_pkg::word_t     issue_b,
  output logic                 res_valid,
  output clmul_pkg::clmul_op_e res_op,
  output clmul_pkg::word_t     res_data
);
  import clmul_pkg::*;

  logic [2*HALF_W-1:0] p_lo;
  logic [2*HALF_W-1:0] p_hi;
  logic [2*HALF_W-1:0] p_mid;
  logic [2*HALF_W-1:0] s1_lo;
  logic [2*HALF_W-1:0] s1_hi;
  logic [2*HALF_W-1:0] s1_mid;
  logic [2*HALF_W-1:0] mid_term;
  clmul_op_e           s1_op;
  logic                s1_valid;
  prod_t               prod;
  word_t               sel;

  poly16_mul mul_lo (
    .a(issue_a[HALF_W-1:0]),
    .b(issue_b[HALF_W-1:0]),
    .r(p_lo)
  );

  poly16_mul mul_hi (
    .a(issue_a[XLEN-1:HALF_W]),
    .b(issue_b[XLEN-1:HALF_W]),
    .r(p_hi)
  );

  // (a_lo + a_hi)(b_lo + b_hi) carries both cross terms at once
  poly16_mul mul_mid (
    .a(issue_a[HALF_W-1:0] ^ issue_a[XLEN-1:HALF_W]),
    .b(issue_b[HALF_W-1:0] ^ issue_b[XLEN-1:HALF_W]),
    .r(p_mid)
  );

  always_ff @(posedge clk_i) begin
    s1_lo  <= p_lo;
    s1_hi  <= p_hi;
    s1_mid <= p_mid;
    s1_op  <= issue_op;
  end

  assign mid_term = s1_mid ^ s1_lo ^ s1_hi;
  assign prod     = {s1_hi, s1_lo} ^ {{HALF_W{1'b0}}, mid_term, {HALF_W{1'b0}}};

  always_comb begin
    unique case (s1_op)
      CLMULH:  sel = prod[2*XLEN-1:XLEN];
      CLMULR:  sel = prod[2*XLEN-2:XLEN-1];  // Bits 62 down to 31
      default: sel = prod[XLEN-1:0];
    endcase
  end

  always_ff @(posedge clk_i) begin
    res_op   <= s1_op;
    res_data <= sel;
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      res_valid <= s1_valid;
    end
  end

endmodule

//--- rtl/clmul_egress.sv
// Result buffer at the output of the unit.
// Sends the head entry whenever the consumer has granted a credit, and
// reports each departure back to the ingress slot counter.

module clmul_egress #(
  parameter int RES_DEPTH = flow_pkg::RES_DEPTH_DEF
) (
  input  logic                 clk_i,
  input  logic                 reset,
  input  logic                 res_valid,
  input  clmul_pkg::clmul_op_e res_op,
  input  clmul_pkg::word_t     res_data,
  output logic                 out_valid,
  output clmul_pkg::clmul_op_e out_op,
  output clmul_pkg::word_t     out_result,
  input  logic                 out_credit,
  output logic                 slot_free
);
  import clmul_pkg::*;
  import flow_pkg::*;

  localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;

  clmul_op_e        buf_op  [RES_DEPTH];
  word_t            buf_res [RES_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CNT_W-1:0] credit_cnt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign out_valid  = (fill != '0) && (credit_cnt != '0);
  assign out_op     = buf_op[rd_ptr];
  assign out_result = buf_res[rd_ptr];
  assign slot_free  = out_valid;  // Each send pops one entry

  // Ingress never lets more than RES_DEPTH items into the core and buffer
  always_ff @(posedge clk_i) begin
    if (res_valid) begin
      buf_op[wr_ptr]  <= res_op;
      buf_res[wr_ptr] <= res_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credit_cnt <= '0;
    end else begin
      if (res_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (out_valid) rd_ptr <= ptr_inc(rd_ptr);
      fill       <= fill + CNT_W'(res_valid) - CNT_W'(out_valid);
      credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(out_valid);
    end
  end

endmodule

//--- rtl/clmul_ingress.sv
// Request queue in front of the multiply pipeline.
// Returns one input credit per issued request and only issues while the
// downstream slot count leaves room in the egress buffer.

module clmul_ingress #(
  parameter int IN_DEPTH  = flow_pkg::IN_DEPTH_DEF,
  parameter int RES_DEPTH = flow_pkg::RES_DEPTH_DEF
) (
  input  logic                 clk_i,
  input  logic                 reset,
  input  logic                 in_valid,
  input  clmul_pkg::clmul_op_e in_op,
  input  clmul_pkg::word_t     in_a,
  input  clmul_pkg::word_t     in_b,
  output logic                 in_credit,
  output logic                 issue_valid,
  output clmul_pkg::clmul_op_e issue_op,
  output clmul_pkg::word_t     issue_a,
  output clmul_pkg::word_t     issue_b,
  input  logic                 slot_free
);
  import clmul_pkg::*;
  import flow_pkg::*;

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

  clmul_op_e        q_op [IN_DEPTH];
  word_t            q_a  [IN_DEPTH];
  word_t            q_b  [IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  logic [CNT_W-1:0] slot_cnt;  // Items in the core plus items in the egress buffer

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign issue_valid = (q_cnt != '0) && (slot_cnt < CNT_W'(RES_DEPTH));
  assign issue_op    = q_op[rd_ptr];
  assign issue_a     = q_a[rd_ptr];
  assign issue_b     = q_b[rd_ptr];

  // The sender holds a credit for every write, so the queue cannot overflow
  always_ff @(posedge clk_i) begin
    if (in_valid) begin
      q_op[wr_ptr] <= in_op;
      q_a[wr_ptr]  <= in_a;
      q_b[wr_ptr]  <= in_b;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      q_cnt     <= '0;
      slot_cnt  <= '0;
      in_credit <= 1'b0;
    end else begin
      in_credit <= issue_valid;  // Credit goes back in the cycle after the issue
      if (in_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (issue_valid) rd_ptr <= ptr_inc(rd_ptr);
      q_cnt    <= q_cnt + CNT_W'(in_valid) - CNT_W'(issue_valid);
      slot_cnt <= slot_cnt + CNT_W'(issue_valid) - CNT_W'(slot_free);
    end
  end

endmodule

//--- rtl/clmul_pkg.sv
// Operation definitions for the carry-less multiply unit.
// Holds the Zbc opcodes and the operand and product types used by every block.

package clmul_pkg;

  parameter int XLEN   = 32;         // Operand and result width
  parameter int HALF_W = XLEN / 2;   // Width of one Karatsuba half

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [2*XLEN-1:0] prod_t; // Top bit of a product is always zero

  // Values follow the low two bits of the Zbc funct3 field
  typedef enum logic [1:0] {
    CLMUL  = 2'b01,
    CLMULR = 2'b10,
    CLMULH = 2'b11
  } clmul_op_e;

endpackage

//--- rtl/clmul_unit.sv
// Top level of the carry-less multiply unit.
// Connects the request queue, the multiply pipeline and the result buffer,
// and hands the queue depths down to them.

module clmul_unit #(
  parameter int IN_DEPTH  = flow_pkg::IN_DEPTH_DEF,
  parameter int RES_DEPTH = flow_pkg::RES_DEPTH_DEF
) (
  input  logic                 clk_i,
  input  logic                 reset,
  input  logic                 in_valid,
  input  clmul_pkg::clmul_op_e in_op,
  input  clmul_pkg::word_t     in_a,
  input  clmul_pkg::word_t     in_b,
  output logic                 in_credit,
  output logic                 out_valid,
  output clmul_pkg::clmul_op_e out_op,
  output clmul_pkg::word_t     out_result,
  input  logic                 out_credit
);
  import clmul_pkg::*;

  logic      issue_valid;
  clmul_op_e issue_op;
  word_t     issue_a;
  word_t     issue_b;
  logic      res_valid;
  clmul_op_e res_op;
  word_t     res_data;
  logic      slot_free;

  clmul_ingress #(
    .IN_DEPTH (IN_DEPTH),
    .RES_DEPTH(RES_DEPTH)
  ) ingress0 (
    .clk_i      (clk_i),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_credit  (in_credit),
    .issue_valid(issue_valid),
    .issue_op   (issue_op),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .slot_free  (slot_free)
  );

  clmul_core core0 (
    .clk_i      (clk_i),
    .reset      (reset),
    .issue_valid(issue_valid),
    .issue_op   (issue_op),
    .issue_a    (issue_a),
    .issue_b    (issue_b),
    .res_valid  (res_valid),
    .res_op     (res_op),
    .res_data   (res_data)
  );

  clmul_egress #(
    .RES_DEPTH(RES_DEPTH)
  ) egress0 (
    .clk_i     (clk_i),
    .reset     (reset),
    .res_valid (res_valid),
    .res_op    (res_op),
    .res_data  (res_data),
    .out_valid (out_valid),
    .out_op    (out_op),
    .out_result(out_result),
    .out_credit(out_credit),
    .slot_free (slot_free)
  );

endmodule

//--- rtl/flow_pkg.sv
// Flow-control definitions shared by the ingress queue and the egress buffer.
// Depths here are only defaults; the top level passes the real ones down.

package flow_pkg;

  parameter int IN_DEPTH_DEF  = 4;
  parameter int RES_DEPTH_DEF = 4;

  // Counters for credits and slots, enough for depths up to 15
  parameter int CNT_W = 4;

endpackage

//--- rtl/poly16_mul.sv
// Combinational 16x16 carry-less multiplier over GF(2).
// Builds the product from shifted AND terms that are folded together by XOR.

module poly16_mul (
  input  logic [clmul_pkg::HALF_W-1:0]   a,
  input  logic [clmul_pkg::HALF_W-1:0]   b,
  output logic [2*clmul_pkg::HALF_W-1:0] r
);
  import clmul_pkg::*;

  // One partial product per bit of b, already shifted into place
  logic [2*HALF_W-1:0] pp [HALF_W];

  for (genvar i = 0; i < HALF_W; i++) begin : g_pp
    assign pp[i] = {{HALF_W{1'b0}}, a & {HALF_W{b[i]}}} << i;
  end

  always_comb begin
    r = '0;
    for (int i = 0; i < HALF_W; i++) begin
      r = r ^ pp[i];           // Addition in GF(2) has no carries
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module clmul_unit_tb -f clmul_unit.f --Mdir obj_dir -o clmul_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/clmul_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG" || [ $status -ne 0 ]; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
exit 0

//--- tb/clmul_patterns.txt
// Columns: opcode (1 CLMUL, 2 CLMULR, 3 CLMULH), operand a, operand b, expected result
// All values in hex, one request per line, results expected in this order
1 00000000 00000000 00000000
1 00000001 12345678 12345678
3 00000001 12345678 00000000
2 00000001 12345678 00000000
1 80000000 80000000 00000000
3 80000000 80000000 40000000
2 80000000 80000000 80000000
1 ffffffff ffffffff 55555555
3 ffffffff ffffffff 55555555
2 ffffffff ffffffff aaaaaaaa
1 00000003 00000003 00000005
1 ffffffff 00000003 00000001
3 ffffffff 00000003 00000001
2 ffffffff 00000003 00000002
3 00010000 00010000 00000001
2 ffff0000 ffff0000 aaaaaaaa
1 0000ffff 0000ffff 55555555
1 deadbeef 00000002 bd5b7dde
2 deadbeef 00000002 00000003
1 00000005 00000007 0000001b
3 0000ffff ffff0000 00005555
1 0000ffff ffff0000 55550000
2 00000100 00800000 00000001
1 80000001 80000001 00000001

//--- tb/clmul_unit_tb.sv
// Self-checking testbench for the carry-less multiply unit.
// Replays tb/clmul_patterns.txt through credit-keeping sender and consumer models,
// paced by an LFSR, with one phase where consumer credits are held back.

module clmul_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import clmul_pkg::*;
  import flow_pkg::*;

  localparam int IN_DEPTH  = IN_DEPTH_DEF;
  localparam int RES_DEPTH = RES_DEPTH_DEF;
  localparam int STALL_AT  = 5;   // Results seen before consumer credits are withheld
  localparam int STALL_LEN = 50;

  logic      clk_i;
  logic      reset;
  logic      in_valid;
  clmul_op_e in_op;
  word_t     in_a;
  word_t     in_b;
  logic      in_credit;
  logic      out_valid;
  clmul_op_e out_op;
  word_t     out_result;
  logic      out_credit;

  clmul_op_e   pat_op[$];
  word_t       pat_a[$];
  word_t       pat_b[$];
  word_t       pat_exp[$];
  logic [31:0] lfsr_state;
  int          cycle;
  int          limit;

  clmul_unit #(
    .IN_DEPTH (IN_DEPTH),
    .RES_DEPTH(RES_DEPTH)
  ) dut0 (
    .clk_i     (clk_i),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_op    (out_op),
    .out_result(out_result),
    .out_credit(out_credit)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at cycle %0d", cycle);
  endtask

  task automatic check_result(input string name, input word_t got, input word_t exp);
    if (got !== exp) abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  task automatic check_op(input string name, input clmul_op_e got, input clmul_op_e exp);
    if (got !== exp) abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[i]    = lfsr_state[0];
    end
  endtask

  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    fd = $fopen("tb/clmul_patterns.txt", "r");
    if (fd == 0) abort_run("Cannot open tb/clmul_patterns.txt");
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp);
      if (n == 4) begin  // Comment lines scan as zero fields
        pat_op.push_back(clmul_op_e'(f_op[1:0]));
        pat_a.push_back(f_a);
        pat_b.push_back(f_b);
        pat_exp.push_back(f_exp);
      end
    end
    $fclose(fd);
    if (pat_op.size() == 0) abort_run("No patterns found in tb/clmul_patterns.txt");
  endtask

  initial begin
    int         send_idx;
    int         recv_idx;
    int         send_credits;
    int         cons_credits;  // Granted to the DUT and not yet used
    int         credits_back;
    int         stall_left;
    bit         stall_started;
    bit         starved;
    logic [3:0] bits;

    reset         = 1'b1;
    in_valid      = 1'b0;
    in_op         = CLMUL;
    in_a          = '0;
    in_b          = '0;
    out_credit    = 1'b0;
    lfsr_state    = 32'hfe19db4a;
    cycle         = 0;
    send_idx      = 0;
    recv_idx      = 0;
    send_credits  = IN_DEPTH;
    cons_credits  = 0;
    credits_back  = 0;
    stall_left    = 0;
    stall_started = 1'b0;
    starved       = 1'b0;
    read_patterns();
    limit = 40 * pat_op.size() + 200;

    for (int i = 1; i <= 8; i++) begin
      @(posedge clk_i);
      cycle++;
      if (i > 1) begin  // Flops hold their reset values from the first edge on
        check_flag("in_credit", in_credit, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
      end
    end
    reset <= 1'b0;

    while (recv_idx < pat_op.size()) begin
      @(posedge clk_i);
      cycle++;
      if (cycle > limit) begin
        abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                            cycle, recv_idx, pat_op.size()));
      end
      if (send_idx == 0) begin
        check_flag("in_credit", in_credit, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
      end
      if (in_credit) begin
        send_credits++;
        credits_back++;
        if (send_credits > IN_DEPTH) abort_run("More input credits came back than were spent");
      end
      if (out_valid) begin
        if (cons_credits == 0) abort_run("A result was sent while the consumer granted no credit");
        cons_credits--;
        check_result("out_result", out_result, pat_exp[recv_idx]);
        check_op("out_op", out_op, pat_op[recv_idx]);
        recv_idx++;
      end

      if (!stall_started && recv_idx >= STALL_AT) begin
        stall_started = 1'b1;
        stall_left    = STALL_LEN;
      end

      draw_bits(1, bits);
      if (stall_left == 0 && bits[0] && cons_credits < RES_DEPTH) begin
        out_credit <= 1'b1;
        cons_credits++;
      end else begin
        out_credit <= 1'b0;
      end

      if (stall_left > 0) begin
        stall_left--;
        if (send_credits == 0 && send_idx < pat_op.size()) starved = 1'b1;
        if (stall_left == 0 && !starved) begin
          abort_run("The sender never ran out of input credits while results were held back");
        end
      end

      draw_bits(2, bits);
      if (send_idx < pat_op.size() && send_credits > 0 && bits[1:0] != 2'b11) begin
        in_valid <= 1'b1;
        in_op    <= pat_op[send_idx];
        in_a     <= pat_a[send_idx];
        in_b     <= pat_b[send_idx];
        send_credits--;
        send_idx++;
      end else begin
        in_valid <= 1'b0;
      end
    end

    in_valid <= 1'b0;
    repeat (10) begin  // Credits keep coming, so a late or repeated result would show up here
      @(posedge clk_i);
      cycle++;
      if (out_valid) abort_run("A result arrived after the last expected one");
      if (in_credit) begin
        send_credits++;
        credits_back++;
      end
      if (cons_credits < RES_DEPTH) begin
        out_credit <= 1'b1;
        cons_credits++;
      end else begin
        out_credit <= 1'b0;
      end
    end

    if (send_credits == IN_DEPTH && credits_back == pat_op.size()) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Sender ends with %0d of %0d credits, %0d returned for %0d requests",
                          send_credits, IN_DEPTH, credits_back, pat_op.size()));
    end
  end

endmodule
